// ==== sdram_pkg.sv ====
// SDRAM controller shared definitions
package sdram_pkg;

	// host side
	typedef logic [22:0] host_addr_t;  // bank, row, column pair
	typedef logic [31:0] host_data_t;  // one 32-bit word
	typedef logic [3:0]  host_sel_t;   // byte enables

	// chip side
	typedef logic [15:0] sd_data_t;    // dq width
	typedef logic [12:0] sd_addr_t;    // multiplexed row/col
	typedef logic [1:0]  sd_ba_t;      // four banks
	typedef logic [3:0]  sd_cmd_t;     // cs_n, ras_n, cas_n, we_n

	// command encodings
	localparam sd_cmd_t CMD_NOP          = 4'b0111;
	localparam sd_cmd_t CMD_ACTIVE       = 4'b0011;  // open a row
	localparam sd_cmd_t CMD_READ         = 4'b0101;
	localparam sd_cmd_t CMD_WRITE        = 4'b0100;
	localparam sd_cmd_t CMD_PRECHARGE    = 4'b0010;  // a10 selects all banks
	localparam sd_cmd_t CMD_AUTO_REFRESH = 4'b0001;
	localparam sd_cmd_t CMD_LOAD_MODE    = 4'b0000;  // mode word on address

	// mode register fields
	localparam logic [2:0] MODE_BURST_LEN_2 = 3'b001;  // a2..a0
	localparam logic       MODE_SEQUENTIAL  = 1'b0;    // a3, burst order

	// host address split
	localparam int HOST_BANK_MSB = 22;
	localparam int HOST_BANK_LSB = 21;
	localparam int HOST_ROW_MSB  = 20;
	localparam int HOST_ROW_LSB  = 8;
	localparam int HOST_COL_MSB  = 7;  // column pair, chip column is twice this

	// a10 is the auto-precharge flag on read/write
	// and the all-banks flag on precharge
	localparam int SD_AP_BIT = 10;

endpackage

// ==== sdram_init_seq.sv ====
// SDRAM power-up sequence
`timescale 1ns/10ps

module sdram_init_seq #(
	parameter int CAS_LATENCY = 3,
	parameter int INIT_CYCLES = 20000
) (
	input  logic               sd_clk,
	input  logic               reset,
	output sdram_pkg::sd_cmd_t  init_cmd,
	output sdram_pkg::sd_addr_t init_addr,
	output logic               init_done
);
	import sdram_pkg::*;

	localparam int CNT_W = $clog2(INIT_CYCLES > 8 ? INIT_CYCLES : 8);
	localparam logic [CNT_W-1:0] GAP = CNT_W'(3);  // 4 cycles between commands
	// single write bursts, standard op, cas latency, sequential, bl2
	localparam sd_addr_t MODE_WORD = {3'b000, 1'b1, 2'b00, 3'(CAS_LATENCY),
		MODE_SEQUENTIAL, MODE_BURST_LEN_2};

	typedef enum logic [2:0] {
		INIT_WAIT,       // power-up settling
		INIT_PRECHARGE,  // precharge-all issued
		INIT_LOAD_1,     // first mode load issued
		INIT_LOAD_2,     // second mode load issued
		INIT_SETTLE,     // covers the pin register stage
		INIT_DONE
	} init_state_t;

	init_state_t      state;
	logic [CNT_W-1:0] cnt;  // shared down-counter

	assign init_done = (state == INIT_DONE);

	always_ff @(posedge sd_clk) begin
		if (reset) begin
			state     <= INIT_WAIT;
			cnt       <= CNT_W'(INIT_CYCLES - 1);
			init_cmd  <= CMD_NOP;
			init_addr <= '0;
		end else begin
			init_cmd <= CMD_NOP;  // nop unless a step fires
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				case (state)
				INIT_WAIT: begin
					init_cmd             <= CMD_PRECHARGE;
					init_addr            <= '0;
					init_addr[SD_AP_BIT] <= 1'b1;  // all banks
					cnt                  <= GAP;
					state                <= INIT_PRECHARGE;
				end
				INIT_PRECHARGE, INIT_LOAD_1: begin
					init_cmd  <= CMD_LOAD_MODE;
					init_addr <= MODE_WORD;
					cnt       <= GAP;
					state     <= (state == INIT_PRECHARGE) ? INIT_LOAD_1 : INIT_LOAD_2;
				end
				INIT_LOAD_2: state <= INIT_SETTLE;
				INIT_SETTLE: state <= INIT_DONE;
				default:     state <= INIT_DONE;  // stays here
				endcase
			end
		end
	end

endmodule

// ==== sdram_refresh_timer.sv ====
// SDRAM refresh interval timer
`timescale 1ns/10ps

module sdram_refresh_timer #(
	parameter int REFRESH_CYCLES = 915
) (
	input  logic sd_clk,
	input  logic reset,
	input  logic init_done,
	input  logic rfsh_taken,
	output logic rfsh_due
);

	localparam int CNT_W = $clog2(REFRESH_CYCLES + 1);

	logic [CNT_W-1:0] cnt;  // cycles since last refresh

	always_ff @(posedge sd_clk) begin
		if (reset) begin
			cnt      <= '0;
			rfsh_due <= 1'b0;
		end else if (rfsh_taken) begin
			cnt      <= '0;  // restart interval
			rfsh_due <= 1'b0;
		end else if (init_done && !rfsh_due) begin
			cnt <= cnt + 1'b1;
			if (cnt == CNT_W'(REFRESH_CYCLES - 1))
				rfsh_due <= 1'b1;  // held until sequencer takes it
		end
	end

endmodule

// ==== sdram_host_port.sv ====
// Host req/ack port
`timescale 1ns/10ps

module sdram_host_port (
	input  logic                   sd_clk,
	input  logic                   reset,
	input  logic                   req,
	input  logic                   we,
	input  sdram_pkg::host_addr_t  addr,
	input  sdram_pkg::host_data_t  wdata,
	input  sdram_pkg::host_sel_t   sel,
	input  logic                   acc_done,
	input  sdram_pkg::host_data_t  acc_rdata,
	input  logic                   acc_busy,
	output logic                   ack,
	output sdram_pkg::host_data_t  rdata,
	output logic                   acc_start,
	output logic                   acc_we,
	output sdram_pkg::host_addr_t  acc_addr,
	output sdram_pkg::host_data_t  acc_wdata,
	output sdram_pkg::host_sel_t   acc_sel
);

	typedef enum logic [1:0] {
		HP_IDLE,
		HP_START,  // access offered to sequencer
		HP_WAIT,   // sequencer working
		HP_ACK     // ack high until req drops
	} hp_state_t;

	hp_state_t state;

	assign acc_start = (state == HP_START);
	assign ack       = (state == HP_ACK);

	always_ff @(posedge sd_clk) begin
		if (reset) begin
			state <= HP_IDLE;
		end else begin
			case (state)
			HP_IDLE:  if (req) state <= HP_START;
			HP_START: if (!acc_busy) state <= HP_WAIT;  // taken this edge
			HP_WAIT:  if (acc_done) state <= HP_ACK;
			HP_ACK:   if (!req) state <= HP_IDLE;
			default:  state <= HP_IDLE;
			endcase
		end
	end

	// operands and read data
	always_ff @(posedge sd_clk) begin
		if (state == HP_IDLE && req) begin
			acc_we    <= we;
			acc_addr  <= addr;
			acc_wdata <= wdata;
			acc_sel   <= sel;
		end
		if (state == HP_WAIT && acc_done)
			rdata <= acc_rdata;  // valid while ack
	end

endmodule

// ==== sdram_access_seq.sv ====
// SDRAM command sequencer
`timescale 1ns/10ps

module sdram_access_seq #(
	parameter int CAS_LATENCY = 3,
	parameter int RCD_CYCLES  = 3,
	parameter int RFC_CYCLES  = 7,
	parameter int RP_CYCLES   = 3
) (
	input  logic                  sd_clk,
	input  logic                  reset,
	input  sdram_pkg::sd_cmd_t    init_cmd,
	input  sdram_pkg::sd_addr_t   init_addr,
	input  logic                  init_done,
	input  logic                  rfsh_due,
	input  logic                  acc_start,
	input  logic                  acc_we,
	input  sdram_pkg::host_addr_t acc_addr,
	input  sdram_pkg::host_data_t acc_wdata,
	input  sdram_pkg::host_sel_t  acc_sel,
	input  sdram_pkg::sd_data_t   sd_dq_in,
	output logic                  rfsh_taken,
	output logic                  acc_busy,
	output logic                  acc_done,
	output sdram_pkg::host_data_t acc_rdata,
	output logic                  sd_cs_n,
	output logic                  sd_ras_n,
	output logic                  sd_cas_n,
	output logic                  sd_we_n,
	output sdram_pkg::sd_addr_t   sd_addr,
	output sdram_pkg::sd_ba_t     sd_ba,
	output logic [1:0]            sd_dqm,
	output sdram_pkg::sd_data_t   sd_dq_out,
	output logic                  sd_dq_oe
);
	import sdram_pkg::*;

	localparam int MAX_A    = (RCD_CYCLES > RFC_CYCLES) ? RCD_CYCLES : RFC_CYCLES;
	localparam int MAX_B    = (RP_CYCLES > CAS_LATENCY) ? RP_CYCLES : CAS_LATENCY;
	localparam int MAX_WAIT = (MAX_A > MAX_B) ? MAX_A : MAX_B;
	localparam int CNT_W    = $clog2(MAX_WAIT + 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_REFRESH,     // auto refresh on pins, then tRFC
		S_ACTIVATE,    // active on pins
		S_RCD_WAIT,
		S_WRITE_LO,    // first write on pins
		S_WRITE_HI,    // second write, auto precharge
		S_READ,        // read on pins
		S_CAS_WAIT,
		S_CAPTURE_LO,  // low half on dq this cycle
		S_CAPTURE_HI,
		S_RECOVER      // auto-precharge recovery
	} seq_state_t;

	seq_state_t       state, state_nx;
	logic [CNT_W-1:0] cnt, cnt_nx;     // wait counter
	logic             op_write, op_write_nx;  // access type held for the whole access
	sd_cmd_t          sd_cmd, cmd_nx;  // registered pin command
	logic             oe_nx, done_nx, taken_nx;
	sd_addr_t         addr_nx;
	sd_ba_t           ba_nx;
	logic [1:0]       dqm_nx;
	sd_data_t         dq_nx;
	sd_data_t         rd_lo, rd_hi, rd_lo_nx, rd_hi_nx;  // captured halves

	// host address fields
	sd_ba_t     bank;
	sd_addr_t   row;
	logic [7:0] col_pair;

	assign bank     = acc_addr[HOST_BANK_MSB:HOST_BANK_LSB];
	assign row      = acc_addr[HOST_ROW_MSB:HOST_ROW_LSB];
	assign col_pair = acc_addr[HOST_COL_MSB:0];

	assign {sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n} = sd_cmd;
	assign acc_rdata = {rd_hi, rd_lo};
	assign acc_busy  = (state != S_IDLE) || rfsh_due || !init_done;  // refresh wins

	always_comb begin
		state_nx    = state;
		cnt_nx      = cnt;
		op_write_nx = op_write;
		cmd_nx      = CMD_NOP;
		oe_nx       = 1'b0;
		done_nx     = 1'b0;
		taken_nx    = 1'b0;
		addr_nx     = sd_addr;
		ba_nx       = sd_ba;
		dqm_nx      = 2'b00;  // reads unmasked
		dq_nx       = sd_dq_out;
		rd_lo_nx    = rd_lo;
		rd_hi_nx    = rd_hi;
		if (!init_done) begin
			cmd_nx  = init_cmd;  // pins follow init sequence
			addr_nx = init_addr;
		end else begin
			case (state)
			S_IDLE: begin
				if (rfsh_due) begin
					cmd_nx   = CMD_AUTO_REFRESH;
					taken_nx = 1'b1;
					cnt_nx   = CNT_W'(RFC_CYCLES - 1);
					state_nx = S_REFRESH;
				end else if (acc_start) begin
					cmd_nx      = CMD_ACTIVE;
					addr_nx     = row;
					ba_nx       = bank;
					op_write_nx = acc_we;
					cnt_nx      = CNT_W'(RCD_CYCLES - 1);
					state_nx    = S_ACTIVATE;
				end
			end
			S_REFRESH: begin
				if (cnt == '0)
					state_nx = S_IDLE;
				else
					cnt_nx = cnt - 1'b1;
			end
			S_ACTIVATE, S_RCD_WAIT: begin
				if (cnt != '0) begin
					cnt_nx   = cnt - 1'b1;
					state_nx = S_RCD_WAIT;
				end else if (op_write) begin
					cmd_nx   = CMD_WRITE;
					addr_nx  = {4'b0000, col_pair, 1'b0};  // column 2c, no precharge
					dqm_nx   = ~acc_sel[1:0];
					dq_nx    = acc_wdata[15:0];
					oe_nx    = 1'b1;
					state_nx = S_WRITE_LO;
				end else begin
					cmd_nx   = CMD_READ;
					addr_nx  = {4'b0000, col_pair, 1'b0};
					addr_nx[SD_AP_BIT] = 1'b1;  // bl2 read, auto precharge
					cnt_nx   = CNT_W'(CAS_LATENCY - 1);
					state_nx = S_READ;
				end
			end
			S_WRITE_LO: begin
				cmd_nx   = CMD_WRITE;
				addr_nx  = {4'b0000, col_pair, 1'b1};  // column 2c+1
				addr_nx[SD_AP_BIT] = 1'b1;
				dqm_nx   = ~acc_sel[3:2];
				dq_nx    = acc_wdata[31:16];
				oe_nx    = 1'b1;
				cnt_nx   = CNT_W'(RP_CYCLES - 1);
				state_nx = S_WRITE_HI;
			end
			S_WRITE_HI, S_RECOVER: begin
				if (cnt == '0) begin
					done_nx  = op_write;  // reads signalled at capture
					state_nx = S_IDLE;
				end else begin
					cnt_nx   = cnt - 1'b1;
					state_nx = S_RECOVER;
				end
			end
			S_READ, S_CAS_WAIT: begin
				if (cnt == '0) begin
					state_nx = S_CAPTURE_LO;
				end else begin
					cnt_nx   = cnt - 1'b1;
					state_nx = S_CAS_WAIT;
				end
			end
			S_CAPTURE_LO: begin
				rd_lo_nx = sd_dq_in;
				state_nx = S_CAPTURE_HI;
			end
			S_CAPTURE_HI: begin
				rd_hi_nx = sd_dq_in;
				done_nx  = 1'b1;
				cnt_nx   = CNT_W'(RP_CYCLES - 1);
				state_nx = S_RECOVER;
			end
			default: state_nx = S_IDLE;
			endcase
		end
	end

	// control state
	always_ff @(posedge sd_clk) begin
		if (reset) begin
			state      <= S_IDLE;
			cnt        <= '0;
			op_write   <= 1'b0;
			sd_cmd     <= CMD_NOP;
			sd_dq_oe   <= 1'b0;
			acc_done   <= 1'b0;
			rfsh_taken <= 1'b0;
		end else begin
			state      <= state_nx;
			cnt        <= cnt_nx;
			op_write   <= op_write_nx;
			sd_cmd     <= cmd_nx;
			sd_dq_oe   <= oe_nx;
			acc_done   <= done_nx;
			rfsh_taken <= taken_nx;
		end
	end

	// address, mask and data path
	always_ff @(posedge sd_clk) begin
		sd_addr   <= addr_nx;
		sd_ba     <= ba_nx;
		sd_dqm    <= dqm_nx;
		sd_dq_out <= dq_nx;
		rd_lo     <= rd_lo_nx;
		rd_hi     <= rd_hi_nx;
	end

endmodule

// ==== sdram_top.sv ====
// SDRAM controller top level
`timescale 1ns/10ps

module sdram_top #(
	parameter int CAS_LATENCY    = 3,
	parameter int RCD_CYCLES     = 3,
	parameter int RFC_CYCLES     = 7,
	parameter int RP_CYCLES      = 3,
	parameter int REFRESH_CYCLES = 915,
	parameter int INIT_CYCLES    = 20000
) (
	input  logic                  sd_clk,
	input  logic                  reset,
	// host port
	input  logic                  req,
	input  logic                  we,
	input  sdram_pkg::host_addr_t addr,
	input  sdram_pkg::host_data_t wdata,
	input  sdram_pkg::host_sel_t  sel,
	output logic                  ack,
	output sdram_pkg::host_data_t rdata,
	// chip pins
	output logic                  sd_cs_n,
	output logic                  sd_ras_n,
	output logic                  sd_cas_n,
	output logic                  sd_we_n,
	output sdram_pkg::sd_addr_t   sd_addr,
	output sdram_pkg::sd_ba_t     sd_ba,
	output logic [1:0]            sd_dqm,
	output sdram_pkg::sd_data_t   sd_dq_out,
	output logic                  sd_dq_oe,
	input  sdram_pkg::sd_data_t   sd_dq_in,
	output logic                  sd_ready
);
	import sdram_pkg::*;

	sd_cmd_t    init_cmd;
	sd_addr_t   init_addr;
	logic       init_done;
	logic       rfsh_due, rfsh_taken;
	logic       acc_start, acc_we, acc_busy, acc_done;
	host_addr_t acc_addr;
	host_data_t acc_wdata, acc_rdata;
	host_sel_t  acc_sel;

	assign sd_ready = init_done;

	sdram_init_seq #(
		.CAS_LATENCY(CAS_LATENCY),
		.INIT_CYCLES(INIT_CYCLES)
	) sdram_init_seq_i (
		.sd_clk(sd_clk), .reset(reset),
		.init_cmd(init_cmd), .init_addr(init_addr), .init_done(init_done)
	);

	sdram_refresh_timer #(
		.REFRESH_CYCLES(REFRESH_CYCLES)
	) sdram_refresh_timer_i (
		.sd_clk(sd_clk), .reset(reset), .init_done(init_done),
		.rfsh_taken(rfsh_taken), .rfsh_due(rfsh_due)
	);

	sdram_host_port sdram_host_port_i (
		.sd_clk(sd_clk), .reset(reset),
		.req(req), .we(we), .addr(addr), .wdata(wdata), .sel(sel),
		.acc_done(acc_done), .acc_rdata(acc_rdata), .acc_busy(acc_busy),
		.ack(ack), .rdata(rdata), .acc_start(acc_start), .acc_we(acc_we),
		.acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_sel(acc_sel)
	);

	sdram_access_seq #(
		.CAS_LATENCY(CAS_LATENCY),
		.RCD_CYCLES(RCD_CYCLES),
		.RFC_CYCLES(RFC_CYCLES),
		.RP_CYCLES(RP_CYCLES)
	) sdram_access_seq_i (
		.sd_clk(sd_clk), .reset(reset),
		.init_cmd(init_cmd), .init_addr(init_addr), .init_done(init_done),
		.rfsh_due(rfsh_due), .acc_start(acc_start), .acc_we(acc_we),
		.acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_sel(acc_sel),
		.sd_dq_in(sd_dq_in), .rfsh_taken(rfsh_taken), .acc_busy(acc_busy),
		.acc_done(acc_done), .acc_rdata(acc_rdata),
		.sd_cs_n(sd_cs_n), .sd_ras_n(sd_ras_n), .sd_cas_n(sd_cas_n), .sd_we_n(sd_we_n),
		.sd_addr(sd_addr), .sd_ba(sd_ba), .sd_dqm(sd_dqm),
		.sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe)
	);

endmodule

// ==== sdram_chip_model.sv ====
// Behavioral SDRAM chip
`timescale 1ns/10ps

module sdram_chip_model #(
	parameter int CAS_LATENCY = 3
) (
	input  logic                sd_clk,
	input  logic                reset,      // commands ignored until released
	input  logic                sd_cs_n,
	input  logic                sd_ras_n,
	input  logic                sd_cas_n,
	input  logic                sd_we_n,
	input  sdram_pkg::sd_addr_t sd_addr,
	input  sdram_pkg::sd_ba_t   sd_ba,
	input  logic [1:0]          sd_dqm,
	input  sdram_pkg::sd_data_t sd_dq_out,
	input  logic                sd_dq_oe,
	output sdram_pkg::sd_data_t sd_dq_in
);
	import sdram_pkg::*;

	sd_data_t   mem [logic [23:0]];  // bank, row, column
	sd_data_t   pipe [0:3];          // read data in flight
	sd_addr_t   open_row [0:3];
	logic [3:0] row_open;
	sd_cmd_t    cmd;
	logic       pall_seen;           // precharge-all seen
	sd_addr_t   mode_word;
	int         mode_loads, refresh_count, cmd_error;

	assign cmd = {sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n};

	function automatic sd_data_t read_half(input logic [23:0] k);
		if (mem.exists(k))
			return mem[k];
		return k[15:0] ^ {k[23:16], k[23:16]};  // fill from whole address
	endfunction

	initial begin
		row_open      = '0;
		pall_seen     = 1'b0;
		mode_word     = '0;
		mode_loads    = 0;
		refresh_count = 0;
		cmd_error     = 0;
		sd_dq_in      = '0;
		for (int i = 0; i < 4; i++)
			pipe[i] = '0;
	end

	always @(posedge sd_clk) begin
		logic [23:0] key, key_hi;
		sd_data_t    old;
		key    = {sd_ba, open_row[sd_ba], sd_addr[8:0]};
		key_hi = {sd_ba, open_row[sd_ba], sd_addr[8:1], 1'b1};  // second beat of bl2
		for (int i = 0; i < 3; i++)
			pipe[i] <= pipe[i + 1];
		pipe[3]  <= '0;
		sd_dq_in <= pipe[0];
		if (!reset) begin
			case (cmd)
			CMD_ACTIVE: begin
				open_row[sd_ba] <= sd_addr;
				row_open[sd_ba] <= 1'b1;
			end
			CMD_READ: begin
				if (!row_open[sd_ba]) begin
					cmd_error <= cmd_error + 1;  // no open row
				end else begin
					pipe[CAS_LATENCY - 2] <= read_half(key);
					pipe[CAS_LATENCY - 1] <= read_half(key_hi);
				end
				if (sd_addr[SD_AP_BIT])
					row_open[sd_ba] <= 1'b0;
			end
			CMD_WRITE: begin
				if (!row_open[sd_ba] || !sd_dq_oe) begin
					cmd_error <= cmd_error + 1;
				end else begin
					old      = read_half(key);
					mem[key] = {sd_dqm[1] ? old[15:8] : sd_dq_out[15:8],
						sd_dqm[0] ? old[7:0] : sd_dq_out[7:0]};  // dqm high masks a byte
				end
				if (sd_addr[SD_AP_BIT])
					row_open[sd_ba] <= 1'b0;
			end
			CMD_PRECHARGE: begin
				if (sd_addr[SD_AP_BIT]) begin
					row_open  <= '0;
					pall_seen <= 1'b1;
				end else begin
					row_open[sd_ba] <= 1'b0;
				end
			end
			CMD_AUTO_REFRESH: begin
				refresh_count <= refresh_count + 1;
				if (row_open != '0)
					cmd_error <= cmd_error + 1;  // refresh needs all banks idle
			end
			CMD_LOAD_MODE: begin
				mode_word  <= sd_addr;
				mode_loads <= mode_loads + 1;
				if (!pall_seen || sd_addr[2:0] != MODE_BURST_LEN_2
						|| sd_addr[3] != MODE_SEQUENTIAL)
					cmd_error <= cmd_error + 1;
			end
			default: ;  // nop, deselect
			endcase
		end
	end

endmodule

// ==== sdram_top_chk.sv ====
// Controller handshake and command checks
`timescale 1ns/10ps

module sdram_top_chk (
	input logic sd_clk,
	input logic reset,
	input logic req,
	input logic ack,
	input logic sd_ready,
	input logic sd_cs_n,
	input logic sd_ras_n,
	input logic sd_cas_n,
	input logic sd_we_n,
	input logic sd_dq_oe
);
	import sdram_pkg::*;

	sd_cmd_t cmd;
	logic    cmd_access;  // active, read or write on pins

	assign cmd        = {sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n};
	assign cmd_access = (cmd == CMD_ACTIVE) || (cmd == CMD_READ) || (cmd == CMD_WRITE);

	ack_needs_req: assert property (@(posedge sd_clk) disable iff (reset)
		$rose(ack) |-> req) else $error("ack rose while req was low");

	ack_follows_req: assert property (@(posedge sd_clk) disable iff (reset)
		$fell(req) |-> ##2 !ack) else $error("ack still high two cycles after req fell");

	no_access_in_init: assert property (@(posedge sd_clk) disable iff (reset)
		!sd_ready |-> !cmd_access) else $error("access command before sd_ready");

	oe_with_write: assert property (@(posedge sd_clk) disable iff (reset)
		sd_dq_oe |-> cmd == CMD_WRITE) else $error("dq driven without a write command");

endmodule

bind sdram_top sdram_top_chk sdram_top_chk_i (.*);

// ==== tb_sdram_top.sv ====
// SDRAM controller testbench
`timescale 1ns/10ps

module tb_sdram_top;
	import sdram_pkg::*;

	localparam int NFIX       = 14;           // directed entries
	localparam int NTST       = NFIX + 50;    // then random ones
	localparam int ACK_LIMIT  = 100;          // cycles from req to ack
	localparam int DROP_LIMIT = 4;            // cycles for ack to fall
	localparam sd_addr_t MODE_EXP = {3'b000, 1'b1, 2'b00, 3'd3, 1'b0, 3'b001};  // single wr, cl3

	logic       sd_clk, reset, req, we, ack, sd_ready;
	host_addr_t addr;
	host_data_t wdata, rdata;
	host_sel_t  sel;
	logic       sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n, sd_dq_oe;
	sd_addr_t   sd_addr;
	sd_ba_t     sd_ba;
	logic [1:0] sd_dqm;
	sd_data_t   sd_dq_out, sd_dq_in;

	string      t_name [NTST];    // stimulus table
	logic       t_we [NTST];
	host_addr_t t_addr [NTST];
	host_data_t t_wdata [NTST];
	host_sel_t  t_sel [NTST];
	host_data_t ref_mem [host_addr_t];  // expected word per address
	host_addr_t pool [8];               // addresses the random phase uses
	int         n_pass, n_fail;
	logic       stalled;                // a handshake was lost

	sdram_top #(.INIT_CYCLES(40), .REFRESH_CYCLES(200)) sdram_top_i (.*);
	sdram_chip_model #(.CAS_LATENCY(3)) sdram_chip_model_i (.*);

	initial begin
		sd_clk = 1'b0;
		forever #2 sd_clk = ~sd_clk;  // 4 ns period
	end

	function automatic host_data_t merge_bytes(input host_data_t old, input host_data_t nw,
			input host_sel_t s);
		host_data_t m;
		m = old;
		for (int b = 0; b < 4; b++)
			if (s[b])
				m[8*b +: 8] = nw[8*b +: 8];
		return m;
	endfunction

	task automatic set_entry(input int i, input string nm, input logic w, input host_addr_t a,
			input host_data_t d, input host_sel_t s);
		t_name[i]  = nm;
		t_we[i]    = w;
		t_addr[i]  = a;
		t_wdata[i] = d;
		t_sel[i]   = s;
	endtask

	task automatic build_table();
		logic [7:0] known;  // pool words with a defined value
		int         k;
		pool[0] = {2'd0, 13'd5, 8'd3};
		pool[1] = {2'd1, 13'd1000, 8'd200};
		pool[2] = {2'd2, 13'd8191, 8'd255};
		pool[3] = {2'd3, 13'd0, 8'd0};
		for (int p = 4; p < 8; p++)
			pool[p] = host_addr_t'($urandom());
		set_entry(0, "wr_bank0", 1'b1, pool[0], 32'h1234_5678, 4'hf);
		set_entry(1, "wr_bank1", 1'b1, pool[1], 32'hcafe_f00d, 4'hf);
		set_entry(2, "wr_bank2", 1'b1, pool[2], 32'h0bad_beef, 4'hf);
		set_entry(3, "wr_bank3", 1'b1, pool[3], 32'ha5a5_5a5a, 4'hf);
		set_entry(4, "rd_bank0", 1'b0, pool[0], '0, '0);
		set_entry(5, "rd_bank1", 1'b0, pool[1], '0, '0);
		set_entry(6, "rd_bank2", 1'b0, pool[2], '0, '0);
		set_entry(7, "rd_bank3", 1'b0, pool[3], '0, '0);
		set_entry(8, "wr_sel_0001", 1'b1, pool[0], 32'haaaa_aa11, 4'b0001);
		set_entry(9, "rd_sel_0001", 1'b0, pool[0], '0, '0);
		set_entry(10, "wr_sel_0110", 1'b1, pool[1], 32'h5522_3366, 4'b0110);
		set_entry(11, "rd_sel_0110", 1'b0, pool[1], '0, '0);
		set_entry(12, "wr_sel_1000", 1'b1, pool[2], 32'h77aa_bbcc, 4'b1000);
		set_entry(13, "rd_sel_1000", 1'b0, pool[2], '0, '0);
		known = 8'h0f;
		for (int i = NFIX; i < NTST; i++) begin
			k = int'($urandom() % 8);
			if (known[k] && $urandom() % 2 == 0)
				set_entry(i, $sformatf("rand_rd_%0d", i), 1'b0, pool[k], '0, '0);
			else if (known[k])
				set_entry(i, $sformatf("rand_wr_%0d", i), 1'b1, pool[k], $urandom(),
					host_sel_t'($urandom()));
			else
				set_entry(i, $sformatf("rand_fill_%0d", i), 1'b1, pool[k], $urandom(), 4'hf);
			known[k] = 1'b1;
		end
	endtask

	// status 0 ok, 1 no ack, 2 ack stuck high, 3 ack before sd_ready
	task automatic run_access(input int i, output host_data_t rd, output int status);
		int n;
		status = 0;
		@(posedge sd_clk);
		req   <= 1'b1;
		we    <= t_we[i];
		addr  <= t_addr[i];
		wdata <= t_wdata[i];
		sel   <= t_sel[i];
		n = 0;
		do begin
			@(posedge sd_clk);
			n++;
		end while (!ack && n < ACK_LIMIT);
		if (!ack)
			status = 1;
		else if (!sd_ready)
			status = 3;
		rd = rdata;  // held while ack is high
		req <= 1'b0;
		n = 0;
		while (ack && n < DROP_LIMIT) begin
			@(posedge sd_clk);
			n++;
		end
		if (ack && status == 0)
			status = 2;
	endtask

	task automatic end_test(input string nm, input logic bad);
		if (bad) begin
			n_fail++;
			$display("test %s: failed", nm);
		end else begin
			n_pass++;
			$display("test %s: ok", nm);
		end
	endtask

	task automatic apply_range(input int first, input int last);
		host_data_t got, exp_word;
		int         status;
		logic       bad;
		for (int i = first; i < last && !stalled; i++) begin
			bad      = 1'b0;
			exp_word = ref_mem.exists(t_addr[i]) ? ref_mem[t_addr[i]] : '0;
			run_access(i, got, status);
			if (status == 1) begin
				$display("test %s: no ack within %0d cycles", t_name[i], ACK_LIMIT);
				stalled = 1'b1;
				bad     = 1'b1;
			end
			if (status == 2) begin
				$display("test %s: ack still high after req fell", t_name[i]);
				bad = 1'b1;
			end
			if (status == 3) begin
				$display("test %s: access completed before sd_ready", t_name[i]);
				bad = 1'b1;
			end
			if (t_we[i]) begin
				ref_mem[t_addr[i]] = merge_bytes(exp_word, t_wdata[i], t_sel[i]);
			end else if (!ref_mem.exists(t_addr[i])) begin
				$display("test %s: read of a word that was never written", t_name[i]);
				bad = 1'b1;
			end else if (status == 0 && got !== exp_word) begin
				$display("ERROR %s expected %h actual %h", t_name[i], exp_word, got);
				bad = 1'b1;
			end
			end_test(t_name[i], bad);
		end
	endtask

	initial begin
		int   n, rc_start, delta;
		logic bad;
		reset   = 1'b1;
		req     = 1'b0;
		we      = 1'b0;
		addr    = '0;
		wdata   = '0;
		sel     = '0;
		n_pass  = 0;
		n_fail  = 0;
		stalled = 1'b0;
		void'($urandom(37));
		build_table();
		repeat (3) @(posedge sd_clk);
		reset <= 1'b0;

		apply_range(0, 1);  // first write raised while init is still running

		bad = 1'b0;  // init sequence and mode word
		n   = 0;
		while (!sd_ready && n < 200) begin
			@(posedge sd_clk);
			n++;
		end
		if (!sd_ready) begin
			$display("test init: sd_ready did not rise within 200 cycles");
			stalled = 1'b1;
			bad     = 1'b1;
		end
		if (!sdram_chip_model_i.pall_seen) begin
			$display("test init: no precharge of all banks was seen");
			bad = 1'b1;
		end
		if (sdram_chip_model_i.mode_loads != 2) begin
			$display("ERROR init_mode_loads expected 2 actual %0d", sdram_chip_model_i.mode_loads);
			bad = 1'b1;
		end
		if (sdram_chip_model_i.mode_word !== MODE_EXP) begin
			$display("ERROR init_mode_word expected %h actual %h", MODE_EXP,
				sdram_chip_model_i.mode_word);
			bad = 1'b1;
		end
		end_test("init", bad);

		apply_range(1, NFIX);

		bad      = 1'b0;  // idle window, refresh only
		rc_start = sdram_chip_model_i.refresh_count;
		repeat (2000) @(posedge sd_clk);
		delta = sdram_chip_model_i.refresh_count - rc_start;
		if (delta < 9 || delta > 11) begin
			$display("ERROR refresh_idle expected 9..11 actual %0d", delta);
			bad = 1'b1;
		end
		end_test("refresh_idle", bad);

		apply_range(NFIX, NTST);

		bad = 1'b0;
		if (sdram_chip_model_i.cmd_error != 0) begin
			$display("ERROR chip_commands expected 0 actual %0d", sdram_chip_model_i.cmd_error);
			bad = 1'b1;
		end
		end_test("chip_commands", bad);

		$display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
sdram_pkg.sv
sdram_init_seq.sv
sdram_refresh_timer.sv
sdram_host_port.sv
sdram_access_seq.sv
sdram_top.sv
sdram_chip_model.sv
sdram_top_chk.sv
tb_sdram_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_sdram_top -f list.f -o sim_tb

# the simulator may stop on an assertion, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
